/* common/disk_bridge_pkg.sv */
// Shared definitions for the disk-image bridge
//   Data, word, buffer address and slot widths
//   Firmware register field and strobe bit positions
//   Image slot count and the slots that always mount read-only

`default_nettype none

package disk_bridge_pkg;

	// ========================================================================
	// Widths
	// ========================================================================
	localparam int NUM_SLOTS = 8;

	typedef logic [7:0]           byte_t;
	typedef logic [31:0]          word_t;
	typedef logic [8:0]           buf_addr_t;
	typedef logic [2:0]           drive_num_t;
	typedef logic [NUM_SLOTS-1:0] drive_mask_t;
	typedef logic [1:0]           file_type_t;
	typedef logic [15:0]          strobe_t;
	typedef logic [63:0]          img_size_t;

	// ========================================================================
	// Firmware register layout
	// ========================================================================
	// Fields of the OUT2 control word
	localparam int OUT2_LBA_BIT    = 0;
	localparam int OUT2_BLK_RD_BIT = 1;
	localparam int OUT2_BLK_WR_BIT = 2;
	localparam int OUT2_DRV_LSB    = 3;

	// Strobe lines used by the bridge
	localparam int WR_IO_BIT   = 5;
	localparam int WR_DATA_BIT = 6;
	localparam int RD_DATA_BIT = 2;

	// Cartridge and executable slots, never writable
	localparam int RO_SLOT_A = 4;
	localparam int RO_SLOT_B = 5;

endpackage

`default_nettype wire

/* disk_bridge/zpu_strobe_decode.sv */
// Firmware strobe decoder
//   Delays and edge-detects the register strobe levels
//   Produces single-cycle data write, data read and block pulses
//   Registers the LBA select and drive number fields

`timescale 1ns/1ps
`default_nettype none

module zpu_strobe_decode (
	input  wire                           clk_sys,
	input  wire                           areset,
	input  wire disk_bridge_pkg::word_t   zpu_out2_i,
	input  wire disk_bridge_pkg::strobe_t zpu_wr_i,
	input  wire disk_bridge_pkg::strobe_t zpu_rd_i,
	output logic                          data_wr_o,
	output logic                          data_rd_o,
	output logic                          io_wr_o,
	output logic                          blk_rd_o,
	output logic                          blk_wr_o,
	output logic                          lba_sel_o,
	output disk_bridge_pkg::drive_num_t   drive_num_o
);

	import disk_bridge_pkg::*;

	// Raw register fields
	logic       data_wr_in;
	logic       data_rd_in;
	logic       io_wr_in;
	logic       blk_rd_in;
	logic       blk_wr_in;
	logic       lba_sel_in;
	drive_num_t drive_num_in;

	// Delay stages for edge detection
	logic data_wr_d1;
	logic data_wr_d2;
	logic data_rd_d1;
	logic blk_rd_d1;
	logic blk_wr_d1;

	assign data_wr_in   = zpu_wr_i[WR_DATA_BIT];
	assign data_rd_in   = zpu_rd_i[RD_DATA_BIT];
	assign io_wr_in     = zpu_wr_i[WR_IO_BIT];
	assign blk_rd_in    = zpu_out2_i[OUT2_BLK_RD_BIT];
	assign blk_wr_in    = zpu_out2_i[OUT2_BLK_WR_BIT];
	assign lba_sel_in   = zpu_out2_i[OUT2_LBA_BIT];
	assign drive_num_in = zpu_out2_i[OUT2_DRV_LSB +: $bits(drive_num_t)];

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			data_wr_d1  <= 1'b0;
			data_wr_d2  <= 1'b0;
			data_rd_d1  <= 1'b0;
			blk_rd_d1   <= 1'b0;
			blk_wr_d1   <= 1'b0;
			data_wr_o   <= 1'b0;
			data_rd_o   <= 1'b0;
			io_wr_o     <= 1'b0;
			blk_rd_o    <= 1'b0;
			blk_wr_o    <= 1'b0;
			lba_sel_o   <= 1'b0;
			drive_num_o <= '0;
		end else begin
			// Data write goes through two stages before its edge is taken
			data_wr_d1 <= data_wr_in;
			data_wr_d2 <= data_wr_d1;
			data_wr_o  <= data_wr_d1 & ~data_wr_d2;

			// Falling edge of the read strobe marks a consumed byte
			data_rd_d1 <= data_rd_in;
			data_rd_o  <= data_rd_d1 & ~data_rd_in;

			blk_rd_d1 <= blk_rd_in;
			blk_rd_o  <= blk_rd_in & ~blk_rd_d1;
			blk_wr_d1 <= blk_wr_in;
			blk_wr_o  <= blk_wr_in & ~blk_wr_d1;

			// Level, not a pulse
			io_wr_o     <= io_wr_in;
			lba_sel_o   <= lba_sel_in;
			drive_num_o <= drive_num_in;
		end
	end

endmodule

`default_nettype wire

/* disk_bridge/image_mount_tracker.sv */
// Image mount tracker
//   Captures slot number, type, read-only flag and size on a mount
//   Flips the mounted toggle seen by the firmware
//   Packs the firmware status byte and muxes the read-data word

`timescale 1ns/1ps
`default_nettype none

module image_mount_tracker (
	input  wire                               clk_sys,
	input  wire                               areset,
	input  wire disk_bridge_pkg::drive_mask_t img_mounted_i,
	input  wire                               img_readonly_i,
	input  wire disk_bridge_pkg::img_size_t   img_size_i,
	input  wire disk_bridge_pkg::file_type_t  image_type_i,
	input  wire                               io_done_i,
	input  wire                               lba_sel_i,
	input  wire disk_bridge_pkg::byte_t       buf_q_i,
	output disk_bridge_pkg::byte_t            zpu_in2_o,
	output disk_bridge_pkg::word_t            zpu_in3_o
);

	import disk_bridge_pkg::*;

	logic       mounted_d1;
	logic       mount_evt;
	logic       mounted;
	drive_num_t file_num;
	drive_num_t file_num_next;
	file_type_t file_type;
	logic       read_only;
	word_t      file_size;

	// Only the transition from no slot to some slot counts
	assign mount_evt = ~mounted_d1 & (|img_mounted_i);

	// Highest of slots 0..6 wins; slot 7 only when it is alone
	always_comb begin
		file_num_next = '0;
		for (int i = 0; i < NUM_SLOTS - 1; i++) begin
			if (img_mounted_i[i])
				file_num_next = drive_num_t'(i);
		end
		if (img_mounted_i == (drive_mask_t'(1) << (NUM_SLOTS - 1)))
			file_num_next = drive_num_t'(NUM_SLOTS - 1);
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			mounted_d1 <= 1'b0;
			mounted    <= 1'b0;
			file_num   <= '0;
			file_type  <= '0;
			read_only  <= 1'b0;
		end else begin
			mounted_d1 <= |img_mounted_i;
			if (mount_evt) begin
				mounted   <= ~mounted;
				file_num  <= file_num_next;
				file_type <= image_type_i;
				read_only <= img_readonly_i | img_mounted_i[RO_SLOT_A] |
					img_mounted_i[RO_SLOT_B];
			end
		end
	end

	// Size is payload for the firmware, low word only
	always_ff @(posedge clk_sys) begin
		if (mount_evt)
			file_size <= img_size_i[31:0];
	end

	assign zpu_in2_o = {read_only, file_type, file_num, mounted, io_done_i};
	assign zpu_in3_o = lba_sel_i ? file_size : word_t'(buf_q_i);

endmodule

`default_nettype wire

/* disk_bridge/sector_buffer.sv */
// Shared sector buffer
//   True dual-port byte memory, host on port A, firmware on port B
//   Auto-incrementing firmware address pointer
//   One cycle of read latency on both ports

`timescale 1ns/1ps
`default_nettype none

module sector_buffer #(
	parameter int BUF_AW = 9
) (
	input  wire                         clk_sys,
	input  wire                         areset,

	// Host port
	input  wire [BUF_AW-1:0]            sd_buff_addr_i,
	input  wire disk_bridge_pkg::byte_t sd_buff_dout_i,
	input  wire                         sd_buff_wr_i,
	output disk_bridge_pkg::byte_t      sd_buff_din_o,

	// Firmware port
	input  wire disk_bridge_pkg::byte_t data_i,
	input  wire                         data_wr_i,
	input  wire                         data_rd_i,
	input  wire                         io_wr_i,
	output disk_bridge_pkg::byte_t      buf_q_o
);

	import disk_bridge_pkg::*;

	localparam int DEPTH = 2 ** BUF_AW;

	byte_t             mem [DEPTH];
	logic [BUF_AW-1:0] fw_ptr;

	// ========================================================================
	// Memory
	// ========================================================================
	// Host and firmware never target the same byte during a transfer
	always_ff @(posedge clk_sys) begin
		if (sd_buff_wr_i)
			mem[sd_buff_addr_i] <= sd_buff_dout_i;
		sd_buff_din_o <= mem[sd_buff_addr_i];

		if (data_wr_i)
			mem[fw_ptr] <= data_i;
		buf_q_o <= mem[fw_ptr];
	end

	// ========================================================================
	// Firmware pointer
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			fw_ptr <= '0;
		end else if (io_wr_i) begin
			// Start of a new sector transfer
			fw_ptr <= '0;
		end else if (data_wr_i || data_rd_i) begin
			fw_ptr <= fw_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* disk_bridge/block_request_ctrl.sv */
// Block request control
//   LBA register loaded from the firmware data word
//   Per-drive read and write request bits toward the host
//   Request clear on any ack and the io_done flag

`timescale 1ns/1ps
`default_nettype none

module block_request_ctrl (
	input  wire                               clk_sys,
	input  wire                               areset,
	input  wire disk_bridge_pkg::word_t       data_i,
	input  wire                               data_wr_i,
	input  wire                               lba_sel_i,
	input  wire                               blk_rd_i,
	input  wire                               blk_wr_i,
	input  wire disk_bridge_pkg::drive_num_t  drive_num_i,
	input  wire disk_bridge_pkg::drive_mask_t sd_ack_i,
	output disk_bridge_pkg::word_t            sd_lba_o,
	output disk_bridge_pkg::drive_mask_t      sd_rd_o,
	output disk_bridge_pkg::drive_mask_t      sd_wr_o,
	output logic                              io_done_o
);

	import disk_bridge_pkg::*;

	logic ack_any;
	logic ack_d1;

	assign ack_any = |sd_ack_i;

	// ========================================================================
	// LBA register
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (data_wr_i && lba_sel_i)
			sd_lba_o <= data_i;
	end

	// ========================================================================
	// Requests and done flag
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			sd_rd_o   <= '0;
			sd_wr_o   <= '0;
			io_done_o <= 1'b0;
			ack_d1    <= 1'b0;
		end else begin
			ack_d1 <= ack_any;

			// A new request marks the transfer as pending
			if (blk_rd_i) begin
				sd_rd_o[drive_num_i] <= 1'b1;
				io_done_o            <= 1'b0;
			end
			if (blk_wr_i) begin
				sd_wr_o[drive_num_i] <= 1'b1;
				io_done_o            <= 1'b0;
			end

			// Host picked it up, drop every request
			if (ack_any) begin
				sd_rd_o <= '0;
				sd_wr_o <= '0;
			end

			// Transfer is over once the ack falls away
			if (ack_d1 && !ack_any)
				io_done_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/sio_disk_bridge.sv */
// Disk-image bridge top level
//   Firmware register strobe decode
//   Image mount tracking and status word packing
//   Shared sector buffer between host and firmware
//   Block request and done flag control

`timescale 1ns/1ps
`default_nettype none

module sio_disk_bridge #(
	parameter int BUF_AW = 9
) (
	input  wire                           clk_sys,
	input  wire                           areset,

	// Firmware register side
	input  wire disk_bridge_pkg::word_t   zpu_out2_i,
	input  wire disk_bridge_pkg::word_t   zpu_out3_i,
	input  wire disk_bridge_pkg::strobe_t zpu_wr_i,
	input  wire disk_bridge_pkg::strobe_t zpu_rd_i,
	output disk_bridge_pkg::byte_t        zpu_in2_o,
	output disk_bridge_pkg::word_t        zpu_in3_o,

	// Host block interface
	output disk_bridge_pkg::word_t        sd_lba_o,
	output disk_bridge_pkg::drive_mask_t  sd_rd_o,
	output disk_bridge_pkg::drive_mask_t  sd_wr_o,
	input  wire disk_bridge_pkg::drive_mask_t sd_ack_i,

	// Host buffer port
	input  wire disk_bridge_pkg::buf_addr_t sd_buff_addr_i,
	input  wire disk_bridge_pkg::byte_t   sd_buff_dout_i,
	input  wire                           sd_buff_wr_i,
	output disk_bridge_pkg::byte_t        sd_buff_din_o,

	// Host mount events
	input  wire disk_bridge_pkg::drive_mask_t img_mounted_i,
	input  wire                           img_readonly_i,
	input  wire disk_bridge_pkg::img_size_t img_size_i,
	input  wire disk_bridge_pkg::file_type_t image_type_i
);

	import disk_bridge_pkg::*;

	logic       data_wr;
	logic       data_rd;
	logic       io_wr;
	logic       blk_rd;
	logic       blk_wr;
	logic       lba_sel;
	drive_num_t drive_num;
	logic       io_done;
	byte_t      buf_q;

	zpu_strobe_decode u_decode (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.zpu_out2_i  (zpu_out2_i),
		.zpu_wr_i    (zpu_wr_i),
		.zpu_rd_i    (zpu_rd_i),
		.data_wr_o   (data_wr),
		.data_rd_o   (data_rd),
		.io_wr_o     (io_wr),
		.blk_rd_o    (blk_rd),
		.blk_wr_o    (blk_wr),
		.lba_sel_o   (lba_sel),
		.drive_num_o (drive_num)
	);

	image_mount_tracker u_mount (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.image_type_i   (image_type_i),
		.io_done_i      (io_done),
		.lba_sel_i      (lba_sel),
		.buf_q_i        (buf_q),
		.zpu_in2_o      (zpu_in2_o),
		.zpu_in3_o      (zpu_in3_o)
	);

	// Only the low BUF_AW address bits reach a reduced buffer
	// A data write with LBA select goes to the LBA register, not the buffer
	sector_buffer #(
		.BUF_AW (BUF_AW)
	) u_buffer (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.sd_buff_addr_i (sd_buff_addr_i[BUF_AW-1:0]),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.data_i         (zpu_out3_i[7:0]),
		.data_wr_i      (data_wr & ~lba_sel),
		.data_rd_i      (data_rd),
		.io_wr_i        (io_wr),
		.sd_buff_din_o  (sd_buff_din_o),
		.buf_q_o        (buf_q)
	);

	block_request_ctrl u_request (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.data_i      (zpu_out3_i),
		.data_wr_i   (data_wr),
		.lba_sel_i   (lba_sel),
		.blk_rd_i    (blk_rd),
		.blk_wr_i    (blk_wr),
		.drive_num_i (drive_num),
		.sd_ack_i    (sd_ack_i),
		.sd_lba_o    (sd_lba_o),
		.sd_rd_o     (sd_rd_o),
		.sd_wr_o     (sd_wr_o),
		.io_done_o   (io_done)
	);

endmodule

`default_nettype wire

/* test/sio_disk_bridge_sva.sv */
// Concurrent assertions on the block request outputs
//   Read and write requests never overlap
//   Each request vector is at most one-hot
//   All requests are gone in the cycle after an ack

`timescale 1ns/1ps
`default_nettype none

module sio_disk_bridge_sva (
	input wire                               clk_sys,
	input wire                               areset,
	input wire disk_bridge_pkg::drive_mask_t sd_ack_i,
	input wire disk_bridge_pkg::drive_mask_t sd_rd_o,
	input wire disk_bridge_pkg::drive_mask_t sd_wr_o
);

	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (areset)
		!((|sd_rd_o) && (|sd_wr_o)))
		else $error("sd_rd_o and sd_wr_o both active");

	rd_onehot: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0(sd_rd_o))
		else $error("sd_rd_o has more than one bit set");

	wr_onehot: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0(sd_wr_o))
		else $error("sd_wr_o has more than one bit set");

	// Ack clears every request on the following edge
	clear_after_ack: assert property (@(posedge clk_sys) disable iff (areset)
		(|sd_ack_i) |=> (sd_rd_o == '0) && (sd_wr_o == '0))
		else $error("request still active after ack");

endmodule

bind block_request_ctrl sio_disk_bridge_sva u_sva (
	.clk_sys  (clk_sys),
	.areset   (areset),
	.sd_ack_i (sd_ack_i),
	.sd_rd_o  (sd_rd_o),
	.sd_wr_o  (sd_wr_o)
);

`default_nettype wire

/* test/tb_sio_disk_bridge.sv */
// Testbench for the disk-image bridge
//   Directed tests for reset, both buffer directions, requests and mounts
//   Value checker with error count, watchdog and xorshift data source

`timescale 1ns/1ps
`default_nettype none

module tb_sio_disk_bridge;

	import disk_bridge_pkg::*;

	// Reset 16, buffer tests about 220, requests 30, mounts 20 cycles
	localparam int WATCHDOG_CYCLES = 4000;

	logic        clk_sys;
	logic        areset;
	word_t       zpu_out2_i;
	word_t       zpu_out3_i;
	strobe_t     zpu_wr_i;
	strobe_t     zpu_rd_i;
	byte_t       zpu_in2_o;
	word_t       zpu_in3_o;
	word_t       sd_lba_o;
	drive_mask_t sd_rd_o;
	drive_mask_t sd_wr_o;
	drive_mask_t sd_ack_i;
	buf_addr_t   sd_buff_addr_i;
	byte_t       sd_buff_dout_i;
	logic        sd_buff_wr_i;
	byte_t       sd_buff_din_o;
	drive_mask_t img_mounted_i;
	logic        img_readonly_i;
	img_size_t   img_size_i;
	file_type_t  image_type_i;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] rng = 32'hc96d;
	logic        toggle_exp = 1'b0;
	byte_t       pattern [16];

	sio_disk_bridge #(.BUF_AW(9)) dut0 (.*);

	always #20 clk_sys = ~clk_sys;

	// ========================================================================
	// Helpers
	// ========================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) step();
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
		end
	endtask

	task automatic strobe_write(input int bit_pos);
		zpu_wr_i[bit_pos] = 1'b1;
		step();
		zpu_wr_i[bit_pos] = 1'b0;
		wait_cycles(4);
	endtask

	// Highest of slots 0..6, slot 7 only when it is mounted alone
	function automatic logic [2:0] expected_file_num(input logic [7:0] mask);
		if (mask == 8'h80)
			return 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (mask[i])
				return 3'(i);
		end
		return 3'd0;
	endfunction

	// ========================================================================
	// Tests
	// ========================================================================
	task automatic test_reset_state();
		check_value("sd_rd_o", 32'(sd_rd_o), 32'h0);
		check_value("sd_wr_o", 32'(sd_wr_o), 32'h0);
		check_value("zpu_in2_o[1:0]", 32'(zpu_in2_o[1:0]), 32'h0);
	endtask

	task automatic test_host_to_fw();
		for (int i = 0; i < 16; i++) begin
			pattern[i]     = byte_t'(next_random());
			sd_buff_addr_i = buf_addr_t'(i);
			sd_buff_dout_i = pattern[i];
			sd_buff_wr_i   = 1'b1;
			step();
		end
		sd_buff_wr_i = 1'b0;
		zpu_out2_i   = 32'h0;
		strobe_write(WR_IO_BIT);
		for (int i = 0; i < 16; i++) begin
			check_value("zpu_in3_o", zpu_in3_o, {24'h0, pattern[i]});
			zpu_rd_i[RD_DATA_BIT] = 1'b1;
			step();
			zpu_rd_i[RD_DATA_BIT] = 1'b0;
			wait_cycles(4);
		end
	endtask

	task automatic test_fw_to_host();
		strobe_write(WR_IO_BIT);
		for (int i = 0; i < 16; i++) begin
			pattern[i] = byte_t'(next_random());
			zpu_out3_i = {24'h0, pattern[i]};
			strobe_write(WR_DATA_BIT);
		end
		for (int i = 0; i < 16; i++) begin
			sd_buff_addr_i = buf_addr_t'(i);
			wait_cycles(2);
			check_value("sd_buff_din_o", 32'(sd_buff_din_o), 32'(pattern[i]));
		end
	endtask

	task automatic request_cycle(input logic is_write, input logic [2:0] drive);
		logic [7:0] want;
		logic       seen;
		want = 8'h1 << drive;
		seen = 1'b0;
		zpu_out2_i = (32'(drive) << 3) | (is_write ? 32'h4 : 32'h2);
		for (int i = 0; i < 3 && !seen; i++) begin
			step();
			seen = is_write ? (sd_wr_o == want) : (sd_rd_o == want);
		end
		if (!seen) begin
			errors++;
			$display("Block request for drive %0d did not appear within 3 cycles", drive);
		end
		check_value("io_done", 32'(zpu_in2_o[0]), 32'h0);
		zpu_out2_i = 32'(drive) << 3;
		sd_ack_i   = want;
		step();
		check_value("sd_rd_o", 32'(sd_rd_o), 32'h0);
		check_value("sd_wr_o", 32'(sd_wr_o), 32'h0);
		sd_ack_i = '0;
		step();
		check_value("io_done", 32'(zpu_in2_o[0]), 32'h1);
	endtask

	task automatic test_requests();
		logic [31:0] lba;
		byte_t       next_byte;
		lba        = next_random();
		zpu_out2_i = 32'h1;
		zpu_out3_i = lba;
		wait_cycles(2);
		strobe_write(WR_DATA_BIT);
		check_value("sd_lba_o", sd_lba_o, lba);

		// The LBA write leaves the pointer at the byte after the last buffer write
		next_byte  = byte_t'(next_random());
		zpu_out2_i = 32'h0;
		zpu_out3_i = {24'h0, next_byte};
		wait_cycles(2);
		strobe_write(WR_DATA_BIT);
		sd_buff_addr_i = buf_addr_t'(16);
		wait_cycles(2);
		check_value("sd_buff_din_o", 32'(sd_buff_din_o), 32'(next_byte));

		request_cycle(1'b0, 3'(next_random()));
		request_cycle(1'b1, 3'(next_random()));
	endtask

	task automatic mount_one(input logic [7:0] mask, input logic ro);
		logic [63:0] size;
		logic [1:0]  ftype;
		size           = {next_random(), next_random()};
		ftype          = 2'(next_random());
		img_size_i     = size;
		image_type_i   = ftype;
		img_readonly_i = ro;
		img_mounted_i  = mask;
		step();
		img_mounted_i  = '0;
		wait_cycles(2);
		toggle_exp = ~toggle_exp;
		check_value("file_num", 32'(zpu_in2_o[4:2]), 32'(expected_file_num(mask)));
		check_value("read_only", 32'(zpu_in2_o[7]), 32'(ro | mask[4] | mask[5]));
		check_value("file_type", 32'(zpu_in2_o[6:5]), 32'(ftype));
		check_value("mounted", 32'(zpu_in2_o[1]), 32'(toggle_exp));
		check_value("zpu_in3_o", zpu_in3_o, size[31:0]);
	endtask

	task automatic test_mounts();
		zpu_out2_i = 32'h1;
		wait_cycles(2);
		mount_one(8'h01, 1'b0);
		mount_one(8'h20, 1'b0);
		mount_one(8'h80, 1'b0);
		mount_one(8'h84, 1'b0);
		mount_one(8'h06, 1'b1);
		mount_one(8'h50, 1'b0);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		clk_sys        = 1'b0;
		areset         = 1'b1;
		zpu_out2_i     = '0;
		zpu_out3_i     = '0;
		zpu_wr_i       = '0;
		zpu_rd_i       = '0;
		sd_ack_i       = '0;
		sd_buff_addr_i = '0;
		sd_buff_dout_i = '0;
		sd_buff_wr_i   = 1'b0;
		img_mounted_i  = '0;
		img_readonly_i = 1'b0;
		img_size_i     = '0;
		image_type_i   = '0;
		repeat (16) @(posedge clk_sys);
		#2;
		areset = 1'b0;
		step();

		test_reset_state();
		test_host_to_fw();
		test_fw_to_host();
		test_requests();
		test_mounts();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
common/disk_bridge_pkg.sv
disk_bridge/zpu_strobe_decode.sv
disk_bridge/image_mount_tracker.sv
disk_bridge/sector_buffer.sv
disk_bridge/block_request_ctrl.sv
src/sio_disk_bridge.sv
test/sio_disk_bridge_sva.sv
test/tb_sio_disk_bridge.sv

/* run.sh */
#!/bin/sh
# Compile and run the disk-image bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sio_disk_bridge \
	-Mdir obj_dir \
	-f list.f

# The simulation may stop on an assertion, the log decides the result
./obj_dir/Vtb_sio_disk_bridge > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
	exit 0
else
	exit 1
fi
